// File: design/spi_clk_gen.sv
`include "spi_master_cfg.svh"

module spi_clk_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic sck_level,
	output logic sck_rise,
	output logic sck_fall
);

	localparam int CNT_W = $clog2(`SPI_DIV);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`SPI_DIV - 1);

	logic [CNT_W-1:0] cnt;

	//////////////////////////////////////////////////
	// Half period counter
	//////////////////////////////////////////////////

	// Strobes are registered together with the level, so each one
	// is high in exactly the cycle where the new level shows
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt       <= '0;
			sck_level <= 1'b0;
			sck_rise  <= 1'b0;
			sck_fall  <= 1'b0;
		end else begin
			sck_rise <= 1'b0;
			sck_fall <= 1'b0;
			if (cnt == CNT_MAX) begin
				cnt       <= '0;
				sck_level <= ~sck_level;
				// Edge direction from the level being left
				sck_rise  <= ~sck_level;
				sck_fall  <= sck_level;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// File: design/spi_master_top.sv
`include "spi_master_cfg.svh"

module spi_master_top (
	input  logic                   CLK50MHZ,
	input  logic                   RST,
	input  spi_pkg::reg_cmd_t      cmd,
	input  logic                   cmd_valid,
	output logic                   busy,
	output logic [`SPI_DATA_W-1:0] rdata,
	output logic                   rdata_valid,
	output logic                   spi_sck,
	output logic                   spi_cs,
	output logic                   spi_mosi,
	input  logic                   spi_miso
);

	// Serial clock timing
	logic sck_level;
	logic sck_rise;
	logic sck_fall;

	// Access block to engine
	spi_pkg::spi_frame_u tx_frame;
	spi_pkg::spi_frame_u rx_frame;
	logic                start;
	logic                done;

	spi_clk_gen clk_gen_i (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.sck_level (sck_level),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall)
	);

	spi_shift_engine engine_i (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.sck_level (sck_level),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall),
		.start     (start),
		.tx_frame  (tx_frame),
		.rx_frame  (rx_frame),
		.done      (done),
		.spi_sck   (spi_sck),
		.spi_cs    (spi_cs),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

	spi_reg_access access_i (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.busy        (busy),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.tx_frame    (tx_frame),
		.start       (start),
		.rx_frame    (rx_frame),
		.done        (done)
	);

endmodule

// File: design/spi_pkg.sv
`include "spi_master_cfg.svh"

package spi_pkg;

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	// One register command where rw = 1 means read
	typedef struct packed {
		logic                   rw;
		logic [`SPI_ADDR_W-1:0] addr;
		logic [`SPI_DATA_W-1:0] wdata;
	} reg_cmd_t;

	//////////////////////////////////////////////////
	// Wire side
	//////////////////////////////////////////////////

	// Field view of a frame with the MSB first on the wire
	typedef struct packed {
		logic                   rd;
		logic [`SPI_ADDR_W-1:0] addr;
		logic [`SPI_DATA_W-1:0] data;
	} frame_fields_t;

	// Same word seen as shift bits or as fields
	typedef union packed {
		logic [`SPI_FRAME_W-1:0] raw;
		frame_fields_t           fld;
	} spi_frame_u;

endpackage

// File: design/spi_reg_access.sv
`include "spi_master_cfg.svh"

module spi_reg_access (
	input  logic                   CLK50MHZ,
	input  logic                   RST,
	input  spi_pkg::reg_cmd_t      cmd,
	input  logic                   cmd_valid,
	output logic                   busy,
	output logic [`SPI_DATA_W-1:0] rdata,
	output logic                   rdata_valid,
	output spi_pkg::spi_frame_u    tx_frame,
	output logic                   start,
	input  spi_pkg::spi_frame_u    rx_frame,
	input  logic                   done
);

	spi_pkg::reg_cmd_t cmd_q;
	logic              is_read;
	logic              accept;

	// Commands arriving while busy are simply dropped
	assign accept = cmd_valid & ~busy;

	//////////////////////////////////////////////////
	// Command capture
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (accept)
			cmd_q <= cmd;
	end

	//////////////////////////////////////////////////
	// Frame encoding
	//////////////////////////////////////////////////

	// Reads send zeros in the unused data field
	always_comb begin
		tx_frame.fld.rd   = cmd_q.rw;
		tx_frame.fld.addr = cmd_q.addr;
		tx_frame.fld.data = cmd_q.rw ? '0 : cmd_q.wdata;
	end

	//////////////////////////////////////////////////
	// Transaction control
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy        <= 1'b0;
			is_read     <= 1'b0;
			start       <= 1'b0;
			rdata_valid <= 1'b0;
		end else begin
			start       <= 1'b0;
			rdata_valid <= 1'b0;
			if (accept) begin
				busy    <= 1'b1;
				is_read <= cmd.rw;
				start   <= 1'b1;
			end else if (done) begin
				// busy and the read pulse end together
				busy        <= 1'b0;
				rdata_valid <= is_read;
			end
		end
	end

	// Read data from the returned frame
	always_ff @(posedge CLK50MHZ) begin
		if (done && is_read)
			rdata <= rx_frame.fld.data;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	assert property (@(posedge CLK50MHZ) disable iff (RST)
		done |-> busy)
		else $error("done from the engine without an open transaction");

endmodule

// File: design/spi_shift_engine.sv
`include "spi_master_cfg.svh"

module spi_shift_engine (
	input  logic                CLK50MHZ,
	input  logic                RST,
	input  logic                sck_level,
	input  logic                sck_rise,
	input  logic                sck_fall,
	input  logic                start,
	input  spi_pkg::spi_frame_u tx_frame,
	output spi_pkg::spi_frame_u rx_frame,
	output logic                done,
	output logic                spi_sck,
	output logic                spi_cs,
	output logic                spi_mosi,
	input  logic                spi_miso
);

	localparam int FRAME_W = `SPI_FRAME_W;
	localparam int BIT_W   = $clog2(FRAME_W + 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_W);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SHIFT,
		ST_FINISH
	} state_t;

	state_t              state;
	spi_pkg::spi_frame_u tx_sr;
	logic [BIT_W-1:0]    bit_cnt;
	logic                sck_en;

	// Gated serial clock that only switches while the level is low
	assign spi_sck = sck_en & sck_level;

	//////////////////////////////////////////////////
	// Control path
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= ST_WAIT;
			bit_cnt  <= '0;
			sck_en   <= 1'b0;
			spi_cs   <= 1'b1;
			spi_mosi <= 1'b0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_WAIT: begin
					if (start) begin
						// First bit is on the line as soon as CS drops
						spi_cs   <= 1'b0;
						spi_mosi <= tx_frame.raw[FRAME_W-1];
						bit_cnt  <= '0;
						state    <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (!sck_en) begin
						// Start on a falling edge so SCK begins low
						if (sck_fall)
							sck_en <= 1'b1;
					end else if (sck_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
					end else if (sck_fall) begin
						if (bit_cnt == LAST_BIT) begin
							sck_en <= 1'b0;
							state  <= ST_FINISH;
						end else begin
							spi_mosi <= tx_sr.raw[FRAME_W-2];
						end
					end
				end
				ST_FINISH: begin
					spi_cs   <= 1'b1;
					spi_mosi <= 1'b0;
					done     <= 1'b1;
					state    <= ST_WAIT;
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_WAIT && start)
			tx_sr <= tx_frame;
		else if (state == ST_SHIFT && sck_en && sck_fall && bit_cnt != LAST_BIT)
			tx_sr.raw <= {tx_sr.raw[FRAME_W-2:0], 1'b0};
	end

	// Held after done until the next frame starts sampling
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_SHIFT && sck_en && sck_rise)
			rx_frame.raw <= {rx_frame.raw[FRAME_W-2:0], spi_miso};
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> !spi_sck)
		else $error("SCK high while CS is deasserted");

	assert property (@(posedge CLK50MHZ) disable iff (RST)
		start |=> (!spi_cs until done))
		else $error("CS released before the frame completed");

	// Host side must wait for done before the next frame
	assert property (@(posedge CLK50MHZ) disable iff (RST)
		start |-> (state == ST_WAIT && !done))
		else $error("start while a frame is in progress");

endmodule

// File: include/spi_master_cfg.svh
`ifndef SPI_MASTER_CFG_SVH
`define SPI_MASTER_CFG_SVH

//////////////////////////////////////////////////
// Serial clock
//////////////////////////////////////////////////

// System clock cycles per SCK half period (at least 2)
`define SPI_DIV 4

//////////////////////////////////////////////////
// Frame layout
//////////////////////////////////////////////////

`define SPI_ADDR_W 7
`define SPI_DATA_W 24

// Read flag, address and data
`define SPI_FRAME_W (1 + `SPI_ADDR_W + `SPI_DATA_W)

`endif

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f spi_master.f \
	--top-module tb_spi_master \
	-Mdir "$BUILD_DIR" \
	-o tb_spi_master

"./$BUILD_DIR/tb_spi_master" | tee "$LOG"

if grep -q 'All tests passed!' "$LOG"; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi

// File: spi_master.f
+incdir+include
design/spi_pkg.sv
design/spi_clk_gen.sv
design/spi_shift_engine.sv
design/spi_reg_access.sv
design/spi_master_top.sv
verif/spi_slave_model.sv
verif/tb_spi_master.sv

// File: verif/spi_slave_model.sv
`include "spi_master_cfg.svh"

module spi_slave_model (
	input  logic spi_sck,
	input  logic spi_cs,
	input  logic spi_mosi,
	output logic spi_miso
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CMD_BITS = 1 + `SPI_ADDR_W;
	localparam int N_REGS   = 1 << `SPI_ADDR_W;

	logic [`SPI_DATA_W-1:0]  mem [0:N_REGS-1];
	logic [`SPI_FRAME_W-1:0] shift_in;
	logic [`SPI_DATA_W-1:0]  tx_word;
	logic [`SPI_FRAME_W-1:0] last_frame;
	int                      frame_count;
	int                      bit_cnt;
	int                      idx;

	//////////////////////////////////////////////////
	// Register device with one frame per CS low period
	//////////////////////////////////////////////////

	initial begin
		for (idx = 0; idx < N_REGS; idx++)
			mem[idx] = '0;
		spi_miso    = 1'b0;
		shift_in    = '0;
		tx_word     = '0;
		last_frame  = '0;
		frame_count = 0;
		bit_cnt     = 0;
		forever begin
			@(negedge spi_cs);
			shift_in = '0;
			bit_cnt  = 0;
			spi_miso = 1'b0;
			while (bit_cnt < `SPI_FRAME_W) begin
				// Mode 0 samples MOSI on the rising edge
				@(posedge spi_sck);
				shift_in = {shift_in[`SPI_FRAME_W-2:0], spi_mosi};
				bit_cnt++;
				// Read flag and address complete
				if (bit_cnt == CMD_BITS)
					tx_word = mem[shift_in[`SPI_ADDR_W-1:0]];
				@(negedge spi_sck);
				if (bit_cnt >= CMD_BITS && bit_cnt < `SPI_FRAME_W) begin
					spi_miso = tx_word[`SPI_DATA_W-1];
					tx_word  = tx_word << 1;
				end else begin
					spi_miso = 1'b0;
				end
			end
			@(posedge spi_cs);
			last_frame = shift_in;
			frame_count++;
			// Write data lands when CS releases
			if (!shift_in[`SPI_FRAME_W-1])
				mem[shift_in[`SPI_FRAME_W-2 -: `SPI_ADDR_W]] = shift_in[`SPI_DATA_W-1:0];
		end
	end

endmodule

// File: verif/tb_spi_master.sv
`include "spi_master_cfg.svh"

module tb_spi_master;

	timeunit 1ns;
	timeprecision 100ps;

	// About 40 frames of roughly 280 cycles each plus margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int SWEEP_LEN      = 16;
	localparam int N_REGS         = 1 << `SPI_ADDR_W;

	logic                   CLK50MHZ;
	logic                   RST;
	spi_pkg::reg_cmd_t      cmd;
	logic                   cmd_valid;
	logic                   busy;
	logic [`SPI_DATA_W-1:0] rdata;
	logic                   rdata_valid;
	logic                   spi_sck;
	logic                   spi_cs;
	logic                   spi_mosi;
	logic                   spi_miso;

	int error_count;
	int check_count;
	int cycle_count;
	int sck_rises;
	int sck_cs_clashes;

	// Expected register contents
	logic [`SPI_DATA_W-1:0] shadow [0:N_REGS-1];
	logic                   written [0:N_REGS-1];

	// Response seen when busy falls
	logic                   end_rvalid;
	logic [`SPI_DATA_W-1:0] end_rdata;

	spi_master_top dut_i (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.busy        (busy),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso)
	);

	spi_slave_model slave_i (
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK50MHZ);
			cycle_count++;
		end
		$display("Run timed out after %0d clock cycles", cycle_count);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////
	// Pin monitors
	//////////////////////////////////////////////////

	initial sck_rises = 0;
	always @(posedge spi_sck) begin
		if (spi_cs === 1'b0)
			sck_rises++;
	end

	initial sck_cs_clashes = 0;
	always @(negedge CLK50MHZ) begin
		if (spi_cs === 1'b1 && spi_sck === 1'b1)
			sck_cs_clashes++;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %0d ns: %s: expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	task automatic send_cmd(input logic rw, input logic [`SPI_ADDR_W-1:0] addr,
			input logic [`SPI_DATA_W-1:0] wdata);
		@(posedge CLK50MHZ);
		#2;
		cmd.rw    = rw;
		cmd.addr  = addr;
		cmd.wdata = wdata;
		cmd_valid = 1'b1;
		@(posedge CLK50MHZ);
		#2;
		cmd_valid = 1'b0;
	endtask

	// rdata_valid pulses in the cycle busy falls
	task automatic wait_idle();
		do
			@(negedge CLK50MHZ);
		while (busy);
		end_rvalid = rdata_valid;
		end_rdata  = rdata;
	endtask

	task automatic write_reg(input logic [`SPI_ADDR_W-1:0] addr,
			input logic [`SPI_DATA_W-1:0] data);
		int frames_before;
		frames_before = slave_i.frame_count;
		send_cmd(1'b0, addr, data);
		wait_idle();
		check_equal(32'(frames_before + 1), 32'(slave_i.frame_count), "frames after write");
		check_equal({1'b0, addr, data}, slave_i.last_frame, "write frame on MOSI");
		check_equal(32'd0, 32'(end_rvalid), "rdata_valid after write");
		shadow[addr]  = data;
		written[addr] = 1'b1;
	endtask

	task automatic read_reg(input logic [`SPI_ADDR_W-1:0] addr);
		int frames_before;
		frames_before = slave_i.frame_count;
		send_cmd(1'b1, addr, '0);
		wait_idle();
		check_equal(32'(frames_before + 1), 32'(slave_i.frame_count), "frames after read");
		check_equal({1'b1, addr, {`SPI_DATA_W{1'b0}}}, slave_i.last_frame, "read frame on MOSI");
		check_equal(32'd1, 32'(end_rvalid), "rdata_valid after read");
		check_equal(32'(shadow[addr]), 32'(end_rdata), "read data");
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic check_reset_state();
		@(negedge CLK50MHZ);
		check_equal(32'd1, 32'(spi_cs), "spi_cs after reset");
		check_equal(32'd0, 32'(spi_sck), "spi_sck after reset");
		check_equal(32'd0, 32'(spi_mosi), "spi_mosi after reset");
		check_equal(32'd0, 32'(busy), "busy after reset");
		check_equal(32'd0, 32'(rdata_valid), "rdata_valid after reset");
		check_equal(32'd0, 32'(slave_i.frame_count), "frames after reset");
	endtask

	task automatic write_then_read();
		write_reg(7'h15, 24'hA5C30F);
		read_reg(7'h15);
		write_reg(7'h7F, 24'h5A3CF0);
		read_reg(7'h7F);
	endtask

	task automatic random_sweep();
		logic [`SPI_ADDR_W-1:0] addrs [SWEEP_LEN];
		int i;
		for (i = 0; i < SWEEP_LEN; i++) begin
			addrs[i] = `SPI_ADDR_W'($urandom);
			write_reg(addrs[i], `SPI_DATA_W'($urandom));
		end
		// Repeated addresses expect the later write
		for (i = 0; i < SWEEP_LEN; i++)
			read_reg(addrs[i]);
	endtask

	task automatic read_unwritten();
		logic [`SPI_ADDR_W-1:0] addr;
		int n;
		addr = `SPI_ADDR_W'($urandom);
		n    = 0;
		while (written[addr] && n < N_REGS) begin
			addr = addr + 1'b1;
			n++;
		end
		read_reg(addr);
		check_equal(32'd0, 32'(end_rdata), "unwritten register");
	endtask

	task automatic frame_shape();
		int rises_before;
		rises_before = sck_rises;
		write_reg(7'h2A, 24'h00FF00);
		check_equal(32'(`SPI_FRAME_W), 32'(sck_rises - rises_before), "SCK rises in a frame");
		check_equal(32'd0, 32'(sck_cs_clashes), "SCK high while CS high");
	endtask

	task automatic drop_while_busy();
		int frames_before;
		frames_before = slave_i.frame_count;
		send_cmd(1'b0, 7'h33, 24'h123456);
		check_equal(32'd1, 32'(busy), "busy during first command");
		// Second strobe lands mid frame
		send_cmd(1'b0, 7'h33, 24'hFEDCBA);
		wait_idle();
		check_equal(32'(frames_before + 1), 32'(slave_i.frame_count),
				"frames with a dropped command");
		check_equal({1'b0, 7'h33, 24'h123456}, slave_i.last_frame, "frame of first command");
		shadow[7'h33]  = 24'h123456;
		written[7'h33] = 1'b1;
		repeat (4) @(negedge CLK50MHZ);
		check_equal(32'd1, 32'(spi_cs), "spi_cs after dropped command");
		check_equal(32'd0, 32'(busy), "busy after dropped command");
		read_reg(7'h33);
	endtask

	initial begin
		void'($urandom(32'h70f7));
		error_count = 0;
		check_count = 0;
		RST         = 1'b1;
		cmd         = '0;
		cmd_valid   = 1'b0;
		for (int a = 0; a < N_REGS; a++) begin
			shadow[a]  = '0;
			written[a] = 1'b0;
		end
		repeat (8) @(posedge CLK50MHZ);
		#2;
		RST = 1'b0;

		check_reset_state();
		write_then_read();
		random_sweep();
		read_unwritten();
		frame_shape();
		drop_while_busy();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
